// ==== src/blimp_pkg.sv ====
// ----------------------------------------------------------------------
// Shared types for the blimp core.
// SEQ_BITS and PHYS_BITS are fixed here, so the top-level parameters
// must agree with them. Only ADD, ADDI and MUL are decoded.
// ----------------------------------------------------------------------
package blimp_pkg;

  // Fixed widths that the top level must match
  localparam int SEQ_BITS   = 5;
  localparam int PHYS_BITS  = 6;
  // Default multiplier depth
  localparam int MUL_STAGES = 4;

  typedef logic [31:0]          word_t;
  typedef logic [31:0]          addr_t;
  typedef logic [4:0]           arch_reg_t;
  typedef logic [SEQ_BITS-1:0]  seq_t;
  typedef logic [PHYS_BITS-1:0] phys_t;

  typedef enum logic [1:0] {OP_ADD, OP_ADDI, OP_MUL, OP_NOP} op_e;
  typedef enum logic {PIPE_ALU, PIPE_MUL} pipe_e;

  // --------------------------------------------------------------------
  // Inter-unit packets
  // --------------------------------------------------------------------

  typedef struct packed {logic valid; addr_t pc; word_t inst;} f_d_s;

  typedef struct packed {
    logic valid; seq_t seq; addr_t pc; op_e op;
    arch_reg_t waddr; phys_t pdst; logic wen;
    word_t op_a; word_t op_b;
  } d_x_s;

  typedef struct packed {
    logic valid; seq_t seq; addr_t pc;
    arch_reg_t waddr; phys_t pdst; logic wen; word_t result;
  } x_w_s;

  typedef struct packed {logic valid; phys_t pdst; logic wen; word_t data;} complete_s;

  typedef struct packed {
    logic valid; addr_t pc; arch_reg_t waddr; logic wen;
    word_t wdata; phys_t old_pdst;
  } commit_s;

  typedef struct packed {
    logic valid; seq_t seq; addr_t pc;
    arch_reg_t waddr; logic wen; phys_t old_pdst;
  } rob_alloc_s;

  // Tags carried unchanged from issue to writeback
  function automatic x_w_s to_x_w(d_x_s d, word_t value);
    x_w_s w;
    w.valid  = d.valid;
    w.seq    = d.seq;
    w.pc     = d.pc;
    w.waddr  = d.waddr;
    w.pdst   = d.pdst;
    w.wen    = d.wen;
    w.result = value;
    return w;
  endfunction

endpackage

// ==== src/fetch_unit.sv ====
// ----------------------------------------------------------------------
// In-order fetch, PC + 4 only, no redirects.
// Memory must answer exactly one cycle after each request.
// At most one request in flight, so one instruction per two cycles.
// ----------------------------------------------------------------------
module fetch_unit (
  input  logic             clk,
  input  logic             rst,
  input  logic             dec_stall,
  output logic             inst_req,
  output blimp_pkg::addr_t inst_addr,
  input  logic             inst_rsp_val,
  input  blimp_pkg::word_t inst_rsp_data,
  output blimp_pkg::f_d_s  fetch
);
  import blimp_pkg::*;

  addr_t pc;
  addr_t req_pc;
  logic  pending;
  logic  buf_val;
  word_t buf_inst;

  // New request only once the previous word has left for decode
  assign inst_req  = !rst && !pending && !buf_val && !dec_stall;
  assign inst_addr = pc;

  // Fresh response or the held word, never both
  always_comb begin : to_decode
    fetch.valid = inst_rsp_val || buf_val;
    fetch.pc    = req_pc;
    fetch.inst  = buf_val ? buf_inst : inst_rsp_data;
  end

  always_ff @(posedge clk) begin : ctrl
    if (rst) begin
      pc      <= '0;
      pending <= 1'b0;
      buf_val <= 1'b0;
    end else begin
      pending <= inst_req;
      // Hold the word while decode stalls
      buf_val <= fetch.valid && dec_stall;
      if (inst_req) pc <= pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin : payload
    if (inst_req) req_pc <= pc;
    if (inst_rsp_val) buf_inst <= inst_rsp_data;
  end

endmodule

// ==== src/decode_issue_unit.sv ====
// ----------------------------------------------------------------------
// Decode, rename and in-order issue to the ALU or multiplier.
// Operands are read at issue, so a source waits until its ready bit is
// set. Physical regs 0..31 start as x0..x31, all holding zero.
// ----------------------------------------------------------------------
module decode_issue_unit #(
  parameter int p_phys_regs = 36
) (
  input  logic                       clk,
  input  logic                       rst,
  input  blimp_pkg::f_d_s            fetch,
  output logic                       dec_stall,
  output blimp_pkg::d_x_s            alu_issue,
  output blimp_pkg::d_x_s            mul_issue,
  output blimp_pkg::rob_alloc_s      rob_alloc,
  input  blimp_pkg::complete_s [1:0] complete,
  input  blimp_pkg::commit_s         commit,
  input  logic                       rob_full
);
  import blimp_pkg::*;

  localparam int ARCH_REGS = 32;
  localparam logic [6:0] OPC_REG = 7'b0110011;
  localparam logic [6:0] OPC_IMM = 7'b0010011;

  op_e       op;
  pipe_e     pipe;
  arch_reg_t rd;
  arch_reg_t rs1;
  arch_reg_t rs2;
  word_t     imm;
  logic      use_rs1;
  logic      use_rs2;
  logic      wen;

  // Rename state
  phys_t                  rat [ARCH_REGS];
  word_t                  prf [p_phys_regs];
  logic [p_phys_regs-1:0] free_bits;
  logic [p_phys_regs-1:0] ready_bits;
  seq_t                   next_seq;

  phys_t prs1;
  phys_t prs2;
  phys_t pdst_new;
  logic  free_any;
  logic  src_ready;
  logic  issue;
  d_x_s  pkt;

  // --------------------------------------------------------------------
  // Decode
  // --------------------------------------------------------------------

  always_comb begin : decode
    rd  = fetch.inst[11:7];
    rs1 = fetch.inst[19:15];
    rs2 = fetch.inst[24:20];
    imm = {{20{fetch.inst[31]}}, fetch.inst[31:20]};
    op  = OP_NOP;
    if (fetch.inst[6:0] == OPC_REG && fetch.inst[14:12] == 3'b000) begin
      if (fetch.inst[31:25] == 7'b0000000) op = OP_ADD;
      else if (fetch.inst[31:25] == 7'b0000001) op = OP_MUL;
    end else if (fetch.inst[6:0] == OPC_IMM && fetch.inst[14:12] == 3'b000) begin
      op = OP_ADDI;
    end
    use_rs1 = (op != OP_NOP);
    use_rs2 = (op == OP_ADD) || (op == OP_MUL);
    // x0 is never written
    wen  = (op != OP_NOP) && (rd != '0);
    pipe = (op == OP_MUL) ? PIPE_MUL : PIPE_ALU;
  end

  // Lowest free physical register
  always_comb begin : pick_free
    pdst_new = '0;
    free_any = 1'b0;
    for (int i = p_phys_regs - 1; i >= 0; i--) begin
      if (free_bits[i]) begin
        pdst_new = phys_t'(i);
        free_any = 1'b1;
      end
    end
  end

  assign prs1      = rat[rs1];
  assign prs2      = rat[rs2];
  assign src_ready = (!use_rs1 || ready_bits[prs1]) && (!use_rs2 || ready_bits[prs2]);

  // Stall decision
  assign dec_stall = fetch.valid && (!src_ready || (wen && !free_any) || rob_full);
  assign issue     = fetch.valid && !dec_stall;

  // --------------------------------------------------------------------
  // Issue packets
  // --------------------------------------------------------------------

  always_comb begin : build_issue
    pkt.valid = 1'b0;
    pkt.seq   = next_seq;
    pkt.pc    = fetch.pc;
    pkt.op    = op;
    pkt.waddr = rd;
    pkt.pdst  = wen ? pdst_new : '0;
    pkt.wen   = wen;
    pkt.op_a  = use_rs1 ? prf[prs1] : '0;
    // Second operand is the immediate for ADDI
    pkt.op_b  = (op == OP_ADDI) ? imm : (use_rs2 ? prf[prs2] : '0);
    alu_issue       = pkt;
    alu_issue.valid = issue && (pipe == PIPE_ALU);
    mul_issue       = pkt;
    mul_issue.valid = issue && (pipe == PIPE_MUL);
    rob_alloc.valid    = issue;
    rob_alloc.seq      = next_seq;
    rob_alloc.pc       = fetch.pc;
    rob_alloc.waddr    = rd;
    rob_alloc.wen      = wen;
    rob_alloc.old_pdst = rat[rd];
  end

  // --------------------------------------------------------------------
  // Rename table, free list, ready bits
  // --------------------------------------------------------------------

  always_ff @(posedge clk) begin : rename_state
    if (rst) begin
      next_seq   <= '0;
      ready_bits <= '1;
      for (int i = 0; i < p_phys_regs; i++) free_bits[i] <= (i >= ARCH_REGS);
      for (int r = 0; r < ARCH_REGS; r++) rat[r] <= phys_t'(r);
    end else begin
      for (int c = 0; c < 2; c++) begin
        if (complete[c].valid && complete[c].wen) ready_bits[complete[c].pdst] <= 1'b1;
      end
      // Old mapping is dead once its successor commits
      if (commit.valid && commit.wen) free_bits[commit.old_pdst] <= 1'b1;
      if (issue) begin
        next_seq <= next_seq + 1'b1;
        if (wen) begin
          free_bits[pdst_new]  <= 1'b0;
          ready_bits[pdst_new] <= 1'b0;
          rat[rd]              <= pdst_new;
        end
      end
    end
  end

  // Register file, written by completions
  always_ff @(posedge clk) begin : regfile
    if (rst) begin
      for (int i = 0; i < p_phys_regs; i++) prf[i] <= '0;
    end else begin
      for (int c = 0; c < 2; c++) begin
        if (complete[c].valid && complete[c].wen) prf[complete[c].pdst] <= complete[c].data;
      end
    end
  end

endmodule

// ==== src/alu_unit.sv ====
// ----------------------------------------------------------------------
// Single-cycle adder pipe for ADD, ADDI and NOP.
// Result appears one cycle after issue; no back-pressure.
// ----------------------------------------------------------------------
module alu_unit (
  input  logic            clk,
  input  logic            rst,
  input  blimp_pkg::d_x_s issue,
  output blimp_pkg::x_w_s result
);
  import blimp_pkg::*;

  word_t sum;

  // ADDI already carries its immediate in op_b
  // NOP still flows through to keep commit order
  assign sum = (issue.op == OP_NOP) ? '0 : issue.op_a + issue.op_b;

  // ------------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin : out_reg
    if (rst) begin
      result.valid <= 1'b0;
    end else begin
      // Tags ride along with the sum
      result <= to_x_w(issue, sum);
    end
  end

endmodule

// ==== src/pipelined_multiplier.sv ====
// ----------------------------------------------------------------------
// Multiplier pipe, p_stages registers deep, keeps the low 32 bits.
// A new multiply may enter every cycle; p_stages must be at least 1.
// ----------------------------------------------------------------------
module pipelined_multiplier #(
  parameter int p_stages = blimp_pkg::MUL_STAGES
) (
  input  logic            clk,
  input  logic            rst,
  input  blimp_pkg::d_x_s issue,
  output blimp_pkg::x_w_s result
);
  import blimp_pkg::*;

  word_t product;
  x_w_s  stage [p_stages];

  // Low half of the product only
  assign product = issue.op_a * issue.op_b;

  // ------------------------------------------------------------------
  // Stage chain
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin : chain
    if (rst) begin
      // Only the valid bits need clearing
      for (int i = 0; i < p_stages; i++) stage[i].valid <= 1'b0;
    end else begin
      stage[0] <= to_x_w(issue, product);
      for (int i = 1; i < p_stages; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  // Last stage feeds writeback
  assign result = stage[p_stages-1];

endmodule

// ==== src/writeback_commit_unit.sv ====
// ----------------------------------------------------------------------
// Writeback and in-order commit through a reorder buffer.
// ROB depth is 2**p_seq_bits, indexed by sequence number.
// Head retires one cycle after its done bit is recorded.
// ----------------------------------------------------------------------
module writeback_commit_unit #(
  parameter int p_seq_bits = blimp_pkg::SEQ_BITS
) (
  input  logic                       clk,
  input  logic                       rst,
  input  blimp_pkg::x_w_s            alu_result,
  input  blimp_pkg::x_w_s            mul_result,
  input  blimp_pkg::rob_alloc_s      rob_alloc,
  output blimp_pkg::complete_s [1:0] complete,
  output blimp_pkg::commit_s         commit,
  output logic                       rob_full
);
  import blimp_pkg::*;

  localparam int DEPTH = 1 << p_seq_bits;

  typedef logic [p_seq_bits-1:0] idx_t;

  // Static part of an entry, written at allocation
  typedef struct packed {addr_t pc; arch_reg_t waddr; logic wen; phys_t old_pdst;} rob_entry_s;

  rob_entry_s         rob_entry [DEPTH];
  word_t              rob_data  [DEPTH];
  logic [DEPTH-1:0]   rob_done;
  idx_t               head;
  idx_t               tail;
  logic [p_seq_bits:0] count;
  x_w_s [1:0]         results;
  logic               retire;

  assign results = {mul_result, alu_result};

  // --------------------------------------------------------------------
  // Completion notices back to decode
  // --------------------------------------------------------------------

  always_comb begin : notify
    for (int i = 0; i < 2; i++) begin
      complete[i].valid = results[i].valid;
      complete[i].pdst  = results[i].pdst;
      complete[i].wen   = results[i].wen;
      complete[i].data  = results[i].result;
    end
  end

  // Head retires when done
  assign retire   = (count != '0) && rob_done[head];
  // Full when pointers meet with entries outstanding
  assign rob_full = (head == tail) && count[p_seq_bits];

  always_comb begin : commit_out
    commit.valid    = retire;
    commit.pc       = rob_entry[head].pc;
    commit.waddr    = rob_entry[head].waddr;
    commit.wen      = rob_entry[head].wen;
    commit.wdata    = rob_data[head];
    commit.old_pdst = rob_entry[head].old_pdst;
  end

  // --------------------------------------------------------------------
  // Pointers and done bits
  // --------------------------------------------------------------------

  always_ff @(posedge clk) begin : rob_ctrl
    if (rst) begin
      head     <= '0;
      tail     <= '0;
      count    <= '0;
      rob_done <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (results[i].valid) rob_done[idx_t'(results[i].seq)] <= 1'b1;
      end
      if (rob_alloc.valid) begin
        rob_done[idx_t'(rob_alloc.seq)] <= 1'b0;
        tail <= tail + 1'b1;
      end
      if (retire) head <= head + 1'b1;
      case ({rob_alloc.valid, retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin : rob_payload
    if (rob_alloc.valid) begin
      rob_entry[idx_t'(rob_alloc.seq)] <= '{rob_alloc.pc, rob_alloc.waddr,
                                            rob_alloc.wen, rob_alloc.old_pdst};
    end
    for (int i = 0; i < 2; i++) begin
      if (results[i].valid) rob_data[idx_t'(results[i].seq)] <= results[i].result;
    end
  end

endmodule

// ==== src/blimp_top.sv ====
// ----------------------------------------------------------------------
// Blimp core top level, one ALU pipe and one multiplier pipe.
// p_seq_bits and $clog2(p_phys_regs) must match blimp_pkg, and
// p_phys_regs must exceed 32. Memory answers one cycle after inst_req.
// ----------------------------------------------------------------------
module blimp_top #(
  parameter int p_seq_bits   = blimp_pkg::SEQ_BITS,
  parameter int p_phys_regs  = 36,
  parameter int p_mul_stages = blimp_pkg::MUL_STAGES
) (
  input  logic               clk,
  input  logic               rst,
  output logic               inst_req,
  output blimp_pkg::addr_t   inst_addr,
  input  logic               inst_rsp_val,
  input  blimp_pkg::word_t   inst_rsp_data,
  output blimp_pkg::commit_s inst_trace
);
  import blimp_pkg::*;

  // Package structs fix these widths
  if (p_seq_bits != SEQ_BITS || $clog2(p_phys_regs) != PHYS_BITS ||
      p_phys_regs <= 32) begin : g_width_check
    $error("blimp_top parameters do not match blimp_pkg widths");
  end

  // ------------------------------------------------------------------
  // Inter-unit wires
  // ------------------------------------------------------------------

  f_d_s            f_d;
  logic            dec_stall;
  d_x_s            alu_issue;
  d_x_s            mul_issue;
  x_w_s            alu_result;
  x_w_s            mul_result;
  rob_alloc_s      rob_alloc;
  complete_s [1:0] complete;
  commit_s         commit;
  logic            rob_full;

  assign inst_trace = commit;

  // ------------------------------------------------------------------
  // Units
  // ------------------------------------------------------------------

  fetch_unit u_fetch (.clk, .rst, .dec_stall, .inst_req, .inst_addr,
                      .inst_rsp_val, .inst_rsp_data, .fetch(f_d));

  decode_issue_unit #(.p_phys_regs(p_phys_regs)) u_decode (
    .clk, .rst, .fetch(f_d), .dec_stall, .alu_issue, .mul_issue,
    .rob_alloc, .complete, .commit, .rob_full);

  alu_unit u_alu (.clk, .rst, .issue(alu_issue), .result(alu_result));

  pipelined_multiplier #(.p_stages(p_mul_stages)) u_mul (
    .clk, .rst, .issue(mul_issue), .result(mul_result));

  writeback_commit_unit #(.p_seq_bits(p_seq_bits)) u_wb (
    .clk, .rst, .alu_result, .mul_result, .rob_alloc,
    .complete, .commit, .rob_full);

endmodule

// ==== sim/blimp_assert.sv ====
// ----------------------------------------------------------------------
// Protocol checks on the blimp_top ports, bound into every instance.
// Assumes a linear PC with no redirects.
// ----------------------------------------------------------------------
module blimp_assert (
  input logic               clk,
  input logic               rst,
  input logic               inst_req,
  input blimp_pkg::commit_s inst_trace
);
  timeunit 1ns;
  timeprecision 100ps;
  import blimp_pkg::*;

  addr_t last_pc;
  logic  have_last;

  // Failures seen so far, read by the testbench
  int unsigned failures = 0;

  // Last committed pc
  always_ff @(posedge clk) begin : track_pc
    if (rst) begin
      have_last <= 1'b0;
    end else if (inst_trace.valid) begin
      have_last <= 1'b1;
      last_pc   <= inst_trace.pc;
    end
  end

  no_trace_in_reset: assert property (@(posedge clk) rst |-> !inst_trace.valid)
    else begin
      failures++;
      $error("commit trace valid during reset");
    end

  // In-order commit of a straight-line program
  pc_step: assert property (@(posedge clk) disable iff (rst)
    (inst_trace.valid && have_last) |-> (inst_trace.pc == last_pc + 32'd4))
    else begin
      failures++;
      $error("committed pc did not advance by 4");
    end

  req_gap: assert property (@(posedge clk) disable iff (rst) inst_req |=> !inst_req)
    else begin
      failures++;
      $error("inst_req high two cycles in a row");
    end

endmodule

bind blimp_top blimp_assert blimp_assert_i (.clk, .rst, .inst_req, .inst_trace);

// ==== sim/blimp_tb.sv ====
// ----------------------------------------------------------------------
// Testbench for blimp_top. Program table with golden register model.
// Memory answers one cycle after inst_req; past the table it holds
// non-subset words that decode as NOPs. Only table commits are checked.
// ----------------------------------------------------------------------
module blimp_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import blimp_pkg::*;

  localparam int SEQ_W        = 5;
  localparam int PHYS_REGS    = 36;
  localparam int MUL_DEPTH    = 4;
  localparam int RESET_CYCLES = 5;
  localparam int MEM_WORDS    = 256;
  localparam int N_PROG       = 40;
  localparam int WATCH_CYCLES = 20 * N_PROG + 100;

  // One program row
  typedef struct packed {
    op_e op; arch_reg_t rd; arch_reg_t rs1; arch_reg_t rs2; logic [11:0] imm;
  } prog_s;

  // Expected commit, in program order
  typedef struct packed {addr_t pc; arch_reg_t waddr; logic wen; word_t wdata;} expect_s;

  // ----------------------------------------------------------------------
  // Program table: op, rd, rs1, rs2, imm
  // ----------------------------------------------------------------------
  localparam prog_s PROG_TABLE [N_PROG] = '{
    // Immediates, sign extension included
    '{OP_ADDI, 5'd1,  5'd0,  5'd0,  12'd5},
    '{OP_ADDI, 5'd2,  5'd0,  5'd0,  12'hffd},
    '{OP_ADDI, 5'd3,  5'd0,  5'd0,  12'h7ff},
    '{OP_ADDI, 5'd4,  5'd0,  5'd0,  12'h800},
    '{OP_ADD,  5'd5,  5'd1,  5'd2,  12'd0},
    '{OP_ADD,  5'd6,  5'd3,  5'd4,  12'd0},
    // x0 targets, wen must stay low
    '{OP_ADDI, 5'd0,  5'd1,  5'd0,  12'd7},
    '{OP_ADD,  5'd0,  5'd1,  5'd3,  12'd0},
    '{OP_ADD,  5'd7,  5'd0,  5'd1,  12'd0},
    // Dependent MUL chain through renaming
    '{OP_MUL,  5'd8,  5'd1,  5'd3,  12'd0},
    '{OP_MUL,  5'd9,  5'd8,  5'd2,  12'd0},
    '{OP_MUL,  5'd10, 5'd9,  5'd9,  12'd0},
    '{OP_MUL,  5'd10, 5'd10, 5'd4,  12'd0},
    // Independent ADDs finish ahead of the MUL
    '{OP_MUL,  5'd11, 5'd4,  5'd4,  12'd0},
    '{OP_ADDI, 5'd12, 5'd0,  5'd0,  12'd100},
    '{OP_ADD,  5'd13, 5'd1,  5'd5,  12'd0},
    '{OP_ADDI, 5'd14, 5'd3,  5'd0,  12'hfff},
    '{OP_ADD,  5'd15, 5'd11, 5'd12, 12'd0},
    // Wide products, low half only
    '{OP_MUL,  5'd16, 5'd11, 5'd3,  12'd0},
    '{OP_MUL,  5'd17, 5'd16, 5'd16, 12'd0},
    '{OP_ADDI, 5'd18, 5'd0,  5'd0,  12'hfff},
    '{OP_MUL,  5'd19, 5'd18, 5'd16, 12'd0},
    '{OP_NOP,  5'd0,  5'd0,  5'd0,  12'd0},
    // Long run of new destinations, forces reuse of freed registers
    '{OP_ADDI, 5'd20, 5'd19, 5'd0,  12'd1},
    '{OP_ADD,  5'd21, 5'd20, 5'd17, 12'd0},
    '{OP_ADDI, 5'd22, 5'd21, 5'd0,  12'd3},
    '{OP_MUL,  5'd23, 5'd22, 5'd2,  12'd0},
    '{OP_ADD,  5'd24, 5'd23, 5'd13, 12'd0},
    '{OP_ADDI, 5'd25, 5'd24, 5'd0,  12'h801},
    '{OP_ADD,  5'd26, 5'd25, 5'd25, 12'd0},
    '{OP_MUL,  5'd27, 5'd26, 5'd1,  12'd0},
    '{OP_ADD,  5'd28, 5'd27, 5'd6,  12'd0},
    '{OP_ADDI, 5'd29, 5'd28, 5'd0,  12'd64},
    '{OP_MUL,  5'd30, 5'd29, 5'd29, 12'd0},
    '{OP_ADD,  5'd31, 5'd30, 5'd10, 12'd0},
    '{OP_ADDI, 5'd1,  5'd1,  5'd0,  12'd1},
    '{OP_ADDI, 5'd1,  5'd1,  5'd0,  12'd1},
    '{OP_ADD,  5'd2,  5'd1,  5'd31, 12'd0},
    '{OP_MUL,  5'd3,  5'd2,  5'd1,  12'd0},
    '{OP_ADD,  5'd5,  5'd3,  5'd15, 12'd0}
  };

  logic    clk = 1'b0;
  logic    rst;
  logic    inst_req;
  addr_t   inst_addr;
  logic    inst_rsp_val;
  word_t   inst_rsp_data;
  commit_s inst_trace;

  word_t   mem [MEM_WORDS];
  expect_s exp_q [N_PROG];
  int      errors  = 0;
  int      checked = 0;
  logic    req_seen = 1'b0;

  blimp_top #(.p_seq_bits(SEQ_W), .p_phys_regs(PHYS_REGS), .p_mul_stages(MUL_DEPTH))
    blimp_top_i (.clk, .rst, .inst_req, .inst_addr, .inst_rsp_val, .inst_rsp_data,
                 .inst_trace);

  always #5 clk = ~clk;

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic check_word(input string test, input word_t exp, input word_t act);
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %h, actual %h", test, exp, act);
    end
  endtask

  task automatic check_addr(input string test, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %h, actual %h", test, exp, act);
    end
  endtask

  task automatic check_reg(input string test, input arch_reg_t exp, input arch_reg_t act);
    if (act !== exp) begin
      errors++;
      $display("error %s: expected x%0d, actual x%0d", test, exp, act);
    end
  endtask

  task automatic check_flag(input string test, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %b, actual %b", test, exp, act);
    end
  endtask

  // RV32 encodings; anything else becomes a non-subset opcode
  function automatic word_t encode(input prog_s p);
    case (p.op)
      OP_ADD:  return {7'b0000000, p.rs2, p.rs1, 3'b000, p.rd, 7'b0110011};
      OP_MUL:  return {7'b0000001, p.rs2, p.rs1, 3'b000, p.rd, 7'b0110011};
      OP_ADDI: return {p.imm, p.rs1, 3'b000, p.rd, 7'b0010011};
      default: return {20'd0, p.rd, 7'b0001111};
    endcase
  endfunction

  // Fill memory and step the golden register model
  task automatic load_program();
    word_t regs [32];
    word_t a;
    word_t b;
    word_t r;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = {i[24:0], 7'b0001111};
    for (int i = 0; i < N_PROG; i++) begin
      mem[i] = encode(PROG_TABLE[i]);
      a = regs[PROG_TABLE[i].rs1];
      b = regs[PROG_TABLE[i].rs2];
      case (PROG_TABLE[i].op)
        OP_ADD:  r = a + b;
        OP_ADDI: r = a + {{20{PROG_TABLE[i].imm[11]}}, PROG_TABLE[i].imm};
        OP_MUL:  r = a * b;
        default: r = '0;
      endcase
      exp_q[i].pc    = addr_t'(4 * i);
      exp_q[i].waddr = PROG_TABLE[i].rd;
      exp_q[i].wen   = (PROG_TABLE[i].op != OP_NOP) && (PROG_TABLE[i].rd != '0);
      exp_q[i].wdata = r;
      if (exp_q[i].wen) regs[PROG_TABLE[i].rd] = r;
    end
  endtask

  // Memory model, one cycle response
  always @(posedge clk) begin : imem
    if (inst_req && !req_seen) begin
      check_addr("first request", '0, inst_addr);
      req_seen = 1'b1;
    end
    inst_rsp_val  <= inst_req && !rst;
    inst_rsp_data <= mem[inst_addr[9:2]];
  end

  // Commit trace against the golden sequence
  always @(posedge clk) begin : trace_monitor
    if (rst) begin
      if (inst_trace.valid) begin
        errors++;
        $display("commit trace was valid while reset was asserted");
      end
    end else if (inst_trace.valid && checked < N_PROG) begin
      check_addr($sformatf("commit %0d pc", checked), exp_q[checked].pc, inst_trace.pc);
      check_reg($sformatf("commit %0d waddr", checked), exp_q[checked].waddr,
                inst_trace.waddr);
      check_flag($sformatf("commit %0d wen", checked), exp_q[checked].wen, inst_trace.wen);
      // Data only matters when a register is written
      if (exp_q[checked].wen) begin
        check_word($sformatf("commit %0d wdata", checked), exp_q[checked].wdata,
                   inst_trace.wdata);
      end
      checked++;
    end
  end

  initial begin : watchdog
    repeat (RESET_CYCLES + WATCH_CYCLES) @(posedge clk);
    $display("timeout: commits stalled after %0d of %0d instructions, errors: %0d",
             checked, N_PROG, errors);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : main
    rst           = 1'b1;
    inst_rsp_val  = 1'b0;
    inst_rsp_data = '0;
    load_program();
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    // Fetch starts in the first cycle out of reset
    @(posedge clk);
    check_flag("first request cycle", 1'b1, inst_req);
    wait (checked == N_PROG);
    @(posedge clk);
    $display("errors: %0d, assertion failures: %0d, commits checked: %0d of %0d",
             errors, blimp_top_i.blimp_assert_i.failures, checked, N_PROG);
    if (errors == 0 && blimp_top_i.blimp_assert_i.failures == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== all.f ====
src/blimp_pkg.sv
src/fetch_unit.sv
src/decode_issue_unit.sv
src/alu_unit.sv
src/pipelined_multiplier.sv
src/writeback_commit_unit.sv
src/blimp_top.sv
sim/blimp_assert.sv
sim/blimp_tb.sv
